/* source/sbox_consts.svh */
`ifndef SBOX_CONSTS_SVH
`define SBOX_CONSTS_SVH

// Boolean shares per byte, only two supported
`define SBOX_SHARES 2

// Register stages through the masked S-box
`define SBOX_STAGES 5

// Result queue entries, also the sender's initial input credits
`define SBOX_FIFO_DEPTH 8

`define SBOX_TAG_W 4
`define SBOX_OUT_CREDIT_W 4

// Extension x^2 + x + lambda over GF(2^4) mod x^4 + x + 1
// lambda = x^3 has trace one, so the extension is irreducible
`define SBOX_LAMBDA 4'h8

`endif

/* source/sbox_pkg.sv */
`include "sbox_consts.svh"

package sbox_pkg;

    typedef logic [`SBOX_TAG_W-1:0] sbTagT;

    // Nibble shares inside the tower field datapath
    typedef logic [`SBOX_SHARES-1:0][3:0] sharedNibT;

    // Real value is shares[0] ^ shares[1]
    typedef struct packed {
        logic [`SBOX_SHARES-1:0][7:0] shares;
    } sharedByteT;

    typedef struct packed {
        sbTagT      tag;
        sharedByteT data;
    } sbReqT;

    typedef struct packed {
        sbTagT      tag;
        sharedByteT data; // S-box output shares
    } sbResT;

    // Fresh masks for one cycle, one field per multiplier
    typedef struct packed {
        logic [3:0] zDelta; // y1 * y0
        logic [3:0] zInvA;  // delta^2 * delta^4
        logic [3:0] zInvB;  // delta^6 * delta^8
        logic [3:0] zHi;
        logic [3:0] zLo;
    } sbRandT;

    // GF(2^4) product, reduced by x^4 + x + 1
    function automatic logic [3:0] gf4Mul(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] acc;
        logic [3:0] sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                acc ^= sh;
            end
            sh = {sh[2:0], 1'b0} ^ (sh[3] ? 4'h3 : 4'h0); // x^4 = x + 1
        end
        return acc;
    endfunction

endpackage

/* source/dom_mul_gf4.sv */
`timescale 1ns/1ps

module dom_mul_gf4 import sbox_pkg::*; (
    input  logic       ClkxCI,
    input  logic       RstxBI,
    input  sharedNibT  aIn,
    input  sharedNibT  bIn,
    input  logic [3:0] zIn,
    output sharedNibT  qOut
);

    sharedNibT innerQ; // Same-domain products
    sharedNibT crossQ; // Cross-domain products, remasked

    // All terms are registered before they meet, so glitches
    // cannot combine the two domains
    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            innerQ <= '0;
            crossQ <= '0;
        end else begin
            innerQ[0] <= gf4Mul(aIn[0], bIn[0]);
            innerQ[1] <= gf4Mul(aIn[1], bIn[1]);
            crossQ[0] <= gf4Mul(aIn[0], bIn[1]) ^ zIn;
            crossQ[1] <= gf4Mul(aIn[1], bIn[0]) ^ zIn; // Same z cancels in the sum
        end
    end

    // Each output share only sees terms of its own domain
    assign qOut[0] = innerQ[0] ^ crossQ[0];
    assign qOut[1] = innerQ[1] ^ crossQ[1];

endmodule

/* source/masked_sbox.sv */
`timescale 1ns/1ps
`include "sbox_consts.svh"

module masked_sbox import sbox_pkg::*; (
    input  logic       ClkxCI,
    input  logic       RstxBI,
    input  sharedByteT xIn,
    input  sbRandT     rnd,
    output sharedByteT qOut
);

    localparam logic [7:0] AffineC = 8'h63;

    // Tower product, element is {y1, y0} = y1*Y + y0 with Y^2 = Y + lambda
    function automatic logic [7:0] towerMul(input logic [7:0] a, input logic [7:0] b);
        logic [3:0] hh;
        logic [3:0] hi;
        logic [3:0] lo;
        hh = gf4Mul(a[7:4], b[7:4]);
        hi = hh ^ gf4Mul(a[7:4], b[3:0]) ^ gf4Mul(a[3:0], b[7:4]);
        lo = gf4Mul(`SBOX_LAMBDA, hh) ^ gf4Mul(a[3:0], b[3:0]);
        return {hi, lo};
    endfunction

    // Linear map given by the images of the eight unit vectors
    function automatic logic [7:0] applyMat(input logic [63:0] cols, input logic [7:0] x);
        logic [7:0] acc;
        acc = '0;
        for (int i = 0; i < 8; i++) begin
            if (x[i]) begin
                acc ^= cols[8*i +: 8];
            end
        end
        return acc;
    endfunction

    // Columns beta^i, beta a root of x^8 + x^4 + x^3 + x + 1 in the tower
    function automatic logic [63:0] buildMapIn();
        logic [63:0] cols;
        logic [7:0]  pw;
        logic [7:0]  pSum;
        cols = '0;
        for (int c = 1; c < 256; c++) begin
            pw = 8'h01;
            pSum = 8'h01;
            for (int i = 1; i <= 8; i++) begin
                pw = towerMul(pw, 8'(c));
                if (i == 1 || i == 3 || i == 4 || i == 8) begin
                    pSum ^= pw;
                end
            end
            // Any of the eight roots gives a field isomorphism
            if (pSum == 8'h00) begin
                pw = 8'h01;
                for (int i = 0; i < 8; i++) begin
                    cols[8*i +: 8] = pw;
                    pw = towerMul(pw, 8'(c));
                end
            end
        end
        return cols;
    endfunction

    // Inverse basis change followed by the linear part of the AES affine map
    function automatic logic [63:0] buildMapOut(input logic [63:0] inCols);
        logic [63:0] cols;
        logic [7:0]  b;
        cols = '0;
        for (int j = 0; j < 8; j++) begin
            for (int a = 0; a < 256; a++) begin
                if (applyMat(inCols, 8'(a)) == 8'(1 << j)) begin
                    b = 8'(a);
                    cols[8*j +: 8] = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]}
                                       ^ {b[4:0], b[7:5]} ^ {b[3:0], b[7:4]};
                end
            end
        end
        return cols;
    endfunction

    localparam logic [63:0] MapInCols = buildMapIn();
    localparam logic [63:0] MapOutCols = buildMapOut(MapInCols);

    logic [`SBOX_SHARES-1:0][7:0] mapQ; // Stage 1
    sharedNibT y1;
    sharedNibT y0;
    sharedNibT deltaMul;
    sharedNibT deltaLinQ; // lambda*y1^2 + y0^2, linear per share
    sharedNibT delta;
    sharedNibT deltaSq;
    sharedNibT deltaQuad;
    sharedNibT delta6;
    sharedNibT delta8Q;
    sharedNibT deltaInv;
    sharedNibT [2:0] hiDlyQ; // y1 held until stage 4
    sharedNibT [2:0] loDlyQ; // y1 ^ y0 held until stage 4
    sharedNibT invHi;
    sharedNibT invLo;

    always_comb begin
        for (int s = 0; s < `SBOX_SHARES; s++) begin
            y1[s] = mapQ[s][7:4];
            y0[s] = mapQ[s][3:0];
            delta[s] = deltaMul[s] ^ deltaLinQ[s];
            deltaSq[s] = gf4Mul(delta[s], delta[s]);
            deltaQuad[s] = gf4Mul(deltaSq[s], deltaSq[s]);
            qOut.shares[s] = applyMat(MapOutCols, {invHi[s], invLo[s]});
        end
        qOut.shares[0] = qOut.shares[0] ^ AffineC; // Constant in one share only
    end

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            mapQ <= '0;
            deltaLinQ <= '0;
            delta8Q <= '0;
            hiDlyQ <= '0;
            loDlyQ <= '0;
        end else begin
            for (int s = 0; s < `SBOX_SHARES; s++) begin
                mapQ[s] <= applyMat(MapInCols, xIn.shares[s]);
                deltaLinQ[s] <= gf4Mul(`SBOX_LAMBDA, gf4Mul(y1[s], y1[s]))
                                ^ gf4Mul(y0[s], y0[s]);
                delta8Q[s] <= gf4Mul(deltaQuad[s], deltaQuad[s]);
            end
            hiDlyQ <= {hiDlyQ[1:0], y1};
            loDlyQ <= {loDlyQ[1:0], y1 ^ y0};
        end
    end

    // Stage 2, norm cross term y1 * y0
    dom_mul_gf4 i_mul_delta (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .aIn    (y1),
        .bIn    (y0),
        .zIn    (rnd.zDelta),
        .qOut   (deltaMul)
    );

    // Stage 3, delta^6
    dom_mul_gf4 i_mul_inv_a (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .aIn    (deltaSq),
        .bIn    (deltaQuad),
        .zIn    (rnd.zInvA),
        .qOut   (delta6)
    );

    // Stage 4, delta^14 = delta^-1, zero stays zero
    dom_mul_gf4 i_mul_inv_b (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .aIn    (delta6),
        .bIn    (delta8Q),
        .zIn    (rnd.zInvB),
        .qOut   (deltaInv)
    );

    // Stage 5, inverse = delta^-1 * conjugate (y1*Y + y1 + y0)
    dom_mul_gf4 i_mul_hi (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .aIn    (deltaInv),
        .bIn    (hiDlyQ[2]),
        .zIn    (rnd.zHi),
        .qOut   (invHi)
    );

    dom_mul_gf4 i_mul_lo (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .aIn    (deltaInv),
        .bIn    (loDlyQ[2]),
        .zIn    (rnd.zLo),
        .qOut   (invLo)
    );

endmodule

/* source/result_fifo.sv */
`timescale 1ns/1ps
`include "sbox_consts.svh"

module result_fifo #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    ClkxCI,
    input  logic    RstxBI,
    input  logic    push,
    input  payloadT din,
    input  logic    pop,
    output payloadT dout,
    output logic    empty
);

    localparam int Depth = `SBOX_FIFO_DEPTH;
    localparam int PtrW = $clog2(Depth);

    payloadT mem [Depth];
    logic [PtrW-1:0] wrPtrQ;
    logic [PtrW-1:0] rdPtrQ;
    logic [PtrW:0]   countQ;
    logic            full;

    assign empty = (countQ == '0);
    assign full = (countQ == (PtrW+1)'(Depth));
    assign dout = mem[rdPtrQ]; // Fall-through head

    always_ff @(posedge ClkxCI) begin
        if (push) begin
            mem[wrPtrQ] <= din;
        end
    end

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            wrPtrQ <= '0;
            rdPtrQ <= '0;
            countQ <= '0;
        end else begin
            if (push) begin
                wrPtrQ <= (wrPtrQ == PtrW'(Depth - 1)) ? '0 : wrPtrQ + 1'b1;
            end
            if (pop) begin
                rdPtrQ <= (rdPtrQ == PtrW'(Depth - 1)) ? '0 : rdPtrQ + 1'b1;
            end
            case ({push, pop})
                2'b10:   countQ <= countQ + 1'b1;
                2'b01:   countQ <= countQ - 1'b1;
                default: countQ <= countQ;
            endcase
        end
    end

    // Input credits are meant to keep the queue from overflowing
    noPushWhenFull: assert property (@(posedge ClkxCI) disable iff (!RstxBI)
        push |-> !full)
        else $error("result_fifo: push while full");

    noPopWhenEmpty: assert property (@(posedge ClkxCI) disable iff (!RstxBI)
        pop |-> !empty)
        else $error("result_fifo: pop while empty");

endmodule

/* source/sbox_flow_ctrl.sv */
`timescale 1ns/1ps
`include "sbox_consts.svh"

module sbox_flow_ctrl import sbox_pkg::*; (
    input  logic  ClkxCI,
    input  logic  RstxBI,
    input  logic  inValid,
    input  sbTagT inTag,
    input  logic  outCredit,
    input  logic  fifoEmpty,
    output sbTagT pushTag,
    output logic  push,
    output logic  pop,
    output logic  outValid,
    output logic  inCredit
);

    logic  [`SBOX_STAGES-1:0] validQ; // One bit per sbox stage
    sbTagT [`SBOX_STAGES-1:0] tagQ;
    logic  [`SBOX_OUT_CREDIT_W-1:0] creditQ;
    logic  [$clog2(`SBOX_FIFO_DEPTH+1)-1:0] queuedQ; // Queue fill seen from push and pop

    // Tag leaves the shift register together with the sbox result
    assign push = validQ[`SBOX_STAGES-1];
    assign pushTag = tagQ[`SBOX_STAGES-1];
    assign pop = !fifoEmpty && (creditQ != '0);

    always_ff @(posedge ClkxCI or negedge RstxBI) begin
        if (!RstxBI) begin
            validQ <= '0;
            creditQ <= '0; // Receiver grants all output credits
            queuedQ <= '0;
            outValid <= 1'b0;
            inCredit <= 1'b0;
        end else begin
            validQ <= {validQ[`SBOX_STAGES-2:0], inValid};
            case ({outCredit, pop})
                2'b10:   creditQ <= creditQ + 1'b1;
                2'b01:   creditQ <= creditQ - 1'b1;
                default: creditQ <= creditQ; // Grant and spend cancel
            endcase
            case ({push, pop})
                2'b10:   queuedQ <= queuedQ + 1'b1;
                2'b01:   queuedQ <= queuedQ - 1'b1;
                default: queuedQ <= queuedQ;
            endcase
            outValid <= pop;
            inCredit <= pop; // Freed queue slot goes back to the sender
        end
    end

    always_ff @(posedge ClkxCI) begin
        tagQ <= {tagQ[`SBOX_STAGES-2:0], inTag};
    end

    creditNoWrap: assert property (@(posedge ClkxCI) disable iff (!RstxBI)
        (creditQ == '1) |-> (!outCredit || pop))
        else $error("sbox_flow_ctrl: output credit counter overflow");

    // Sender credits bound everything between input and output register
    inFlightBound: assert property (@(posedge ClkxCI) disable iff (!RstxBI)
        ($countones(validQ) + queuedQ) <= `SBOX_FIFO_DEPTH)
        else $error("sbox_flow_ctrl: pipeline plus queue exceed queue depth");

endmodule

/* source/sbox_unit_top.sv */
`timescale 1ns/1ps

module sbox_unit_top import sbox_pkg::*; (
    input  logic   ClkxCI,
    input  logic   RstxBI,
    input  logic   inValid,
    input  sbReqT  inReq,
    input  sbRandT inRnd,
    input  logic   outCredit,
    output logic   inCredit,
    output logic   outValid,
    output sbResT  outRes
);

    sbTagT      pushTag;
    logic       push;
    logic       pop;
    logic       fifoEmpty;
    sharedByteT sboxOut;
    sbResT      fifoIn;
    sbResT      fifoHead;

    sbox_flow_ctrl i_sbox_flow_ctrl (
        .ClkxCI    (ClkxCI),
        .RstxBI    (RstxBI),
        .inValid   (inValid),
        .inTag     (inReq.tag),
        .outCredit (outCredit),
        .fifoEmpty (fifoEmpty),
        .pushTag   (pushTag),
        .push      (push),
        .pop       (pop),
        .outValid  (outValid),
        .inCredit  (inCredit)
    );

    // Runs every cycle, validity lives in the control shift register
    masked_sbox i_masked_sbox (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .xIn    (inReq.data),
        .rnd    (inRnd),
        .qOut   (sboxOut)
    );

    assign fifoIn.tag = pushTag;
    assign fifoIn.data = sboxOut;

    result_fifo #(
        .payloadT (sbResT)
    ) i_result_fifo (
        .ClkxCI (ClkxCI),
        .RstxBI (RstxBI),
        .push   (push),
        .din    (fifoIn),
        .pop    (pop),
        .dout   (fifoHead),
        .empty  (fifoEmpty)
    );

    always_ff @(posedge ClkxCI) begin
        if (pop) begin
            outRes <= fifoHead; // Valid together with outValid
        end
    end

endmodule

/* tests/tb_sbox_ref.svh */
`ifndef TB_SBOX_REF_SVH
`define TB_SBOX_REF_SVH

// AES S-box, entry 0 in the leftmost byte
localparam logic [0:255][7:0] SboxTable = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
};

// Real byte behind a two-share value
function automatic logic [7:0] unmask(input sharedByteT v);
    return v.shares[0] ^ v.shares[1];
endfunction

`endif

/* tests/tb_sbox_unit.sv */
`timescale 1ns/1ps
`include "sbox_consts.svh"

module tb_sbox_unit import sbox_pkg::*; ();

    localparam int WaitLimit = 500;
    localparam int IdleLatency = 6;

    logic   ClkxCI = 1'b0;
    logic   RstxBI;
    logic   inValid = 1'b0;
    sbReqT  inReq = '0;
    sbRandT inRnd = '0;
    logic   outCredit = 1'b0;
    logic   inCredit;
    logic   outValid;
    sbResT  outRes;

    int    seed = 32'hc36a;
    int    sent = 0;
    int    creditReturns = 0;
    int    grants = 0; // Output credits sampled by the DUT
    int    validCnt = 0;
    int    valueErrs = 0;
    int    protoErrs = 0;
    int    timeoutErrs = 0;
    bit    grantOn = 1'b0;
    sbTagT tagCnt = '0;
    logic [`SBOX_TAG_W+7:0] expQ [$]; // {tag, real byte} in request order

    `include "tb_sbox_ref.svh"

    always #4 ClkxCI = ~ClkxCI;

    sbox_unit_top i_sbox_unit_top (.*);

    creditEcho: assert property (@(posedge ClkxCI) inCredit == outValid)
        else begin
            protoErrs++;
            $display("Mismatch inCredit: got %h exp %h", $sampled(inCredit), $sampled(outValid));
        end

    resetQuiet: assert property (@(posedge ClkxCI)
        (!RstxBI || $past(!RstxBI)) |-> (!outValid && !inCredit))
        else begin
            protoErrs++;
            $display("outValid or inCredit was high during reset or right after it");
        end

    // Receiver model and scoreboard
    always @(posedge ClkxCI) begin
        logic [`SBOX_TAG_W+7:0] expEntry;
        inRnd <= 20'($random(seed)); // Fresh masks every cycle
        if (grantOn && (grants + int'(outCredit) - validCnt < 4) && ($random(seed) & 1) == 1) begin
            outCredit <= 1'b1;
        end else begin
            outCredit <= 1'b0;
        end
        if (outCredit) grants <= grants + 1;
        if (inCredit) begin
            creditReturns <= creditReturns + 1;
            assert (creditReturns < sent) else begin
                protoErrs++;
                $display("inCredit returned more credits than requests were sent");
            end
        end
        if (outValid) begin
            validCnt <= validCnt + 1;
            assert (validCnt < grants) else begin
                protoErrs++;
                $display("outValid pulsed without an output credit");
            end
            assert (expQ.size() > 0) else begin
                protoErrs++;
                $display("outValid pulsed with no request outstanding");
            end
            if (expQ.size() > 0) begin
                expEntry = expQ.pop_front();
                assert (outRes.tag == expEntry[`SBOX_TAG_W+7:8]) else begin
                    valueErrs++;
                    $display("Mismatch outRes.tag: got %h exp %h", outRes.tag,
                             expEntry[`SBOX_TAG_W+7:8]);
                end
                assert (unmask(outRes.data) == SboxTable[expEntry[7:0]]) else begin
                    valueErrs++;
                    $display("Mismatch outRes.data: got %h exp %h (input %h)",
                             unmask(outRes.data), SboxTable[expEntry[7:0]], expEntry[7:0]);
                end
            end
        end
    end

    task automatic reportTimeout(input string what);
        timeoutErrs++;
        $display("Timeout: %s", what);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge ClkxCI);
            inValid <= 1'b0;
        end
    endtask

    task automatic sendByte(input logic [7:0] realByte);
        int n;
        logic [7:0] mask;
        n = 0;
        @(posedge ClkxCI);
        while (sent - creditReturns >= `SBOX_FIFO_DEPTH && n < WaitLimit) begin
            inValid <= 1'b0; // Out of input credits
            @(posedge ClkxCI);
            n++;
        end
        if (sent - creditReturns >= `SBOX_FIFO_DEPTH) begin
            inValid <= 1'b0;
            reportTimeout("the sender got no input credit back");
        end else begin
            mask = 8'($random(seed));
            inValid <= 1'b1;
            inReq <= {tagCnt, mask ^ realByte, mask};
            expQ.push_back({tagCnt, realByte});
            tagCnt++;
            sent++;
        end
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < WaitLimit) begin
            idleCycles(1);
            n++;
        end
        if (expQ.size() != 0) reportTimeout("not all expected results arrived");
        idleCycles(2);
    endtask

    // Queue empty and an output credit held, so no waiting inside the DUT
    task automatic checkIdleLatency(input logic [7:0] realByte);
        int n;
        waitDrained();
        grantOn = 1'b1;
        n = 0;
        while (grants - validCnt < 1 && n < WaitLimit) begin
            idleCycles(1);
            n++;
        end
        grantOn = 1'b0;
        if (grants - validCnt < 1) begin
            reportTimeout("no output credit was granted before the latency check");
        end else begin
            sendByte(realByte);
            idleCycles(1); // Edge where the DUT samples the request
            n = 0;
            while (!outValid && n < WaitLimit) begin
                @(posedge ClkxCI);
                n++;
            end
            if (!outValid) begin
                reportTimeout("outValid never followed the idle request");
            end else begin
                // Seen one edge after the edge that raises it
                assert (n - 1 == IdleLatency) else begin
                    valueErrs++;
                    $display("Mismatch idle latency: got %h exp %h", n - 1, IdleLatency);
                end
            end
        end
    endtask

    initial begin
        logic [7:0] offset;
        int n;
        int returnsBefore;
        int validBefore;
        RstxBI <= 1'b0;
        repeat (3) @(posedge ClkxCI);
        RstxBI <= 1'b1;
        idleCycles(2);
        checkIdleLatency(8'h00);
        checkIdleLatency(8'h01);
        checkIdleLatency(8'hff);

        // Every byte once in a random order, with input and credit gaps
        grantOn = 1'b1;
        offset = 8'($random(seed));
        for (int i = 0; i < 256; i++) begin
            sendByte(8'(i) ^ offset);
            if (($random(seed) & 3) == 0) idleCycles(1);
        end

        // Withhold output credits until pipeline and queue are full
        grantOn = 1'b0;
        idleCycles(2);
        n = 0;
        while ((grants != validCnt || sent - creditReturns < `SBOX_FIFO_DEPTH) && n < WaitLimit) begin
            if (sent - creditReturns < `SBOX_FIFO_DEPTH) sendByte(8'($random(seed)));
            else idleCycles(1);
            n++;
        end
        if (n >= WaitLimit) reportTimeout("the queue did not fill while credits were withheld");
        returnsBefore = creditReturns;
        validBefore = validCnt;
        idleCycles(20);
        assert (creditReturns == returnsBefore && validCnt == validBefore) else begin
            protoErrs++;
            $display("inCredit or outValid pulsed while output credits were withheld");
        end
        grantOn = 1'b1;
        waitDrained();

        assert (validCnt == sent && creditReturns == sent) else begin
            protoErrs++;
            $display("Results or credits lost: %0d sent, %0d out, %0d credits back",
                     sent, validCnt, creditReturns);
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout", valueErrs, protoErrs, timeoutErrs);
        if (valueErrs + protoErrs + timeoutErrs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
+incdir+tests
source/sbox_pkg.sv
source/dom_mul_gf4.sv
source/masked_sbox.sv
source/result_fifo.sv
source/sbox_flow_ctrl.sv
source/sbox_unit_top.sv
tests/tb_sbox_unit.sv
